/* project.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/line_align.sv
hdl/way_lru.sv
hdl/cache_ways.sv
hdl/dcache_top.sv
bench/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/sim_dcache)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* bench/tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tb_dcache;
    import dcache_pkg::*;

    // limit far above the roughly 55 cycles the run takes
    localparam int CYCLE_LIMIT = 400;

    logic                  clock;
    logic                  reset;
    logic                  load_valid;
    logic                  store_valid;
    logic                  refill_valid;
    logic                  refill_dirty;
    logic [`DC_ADDR_W-1:0] load_addr;
    logic [`DC_ADDR_W-1:0] store_addr;
    logic [`DC_ADDR_W-1:0] refill_addr;
    mem_size_t             load_size;
    mem_size_t             store_size;
    logic [31:0]           store_data;
    logic [`DC_LINE_W-1:0] refill_data;
    logic                  load_hit;
    logic                  load_miss;
    logic                  load_stall;
    logic                  store_hit;
    logic                  store_miss;
    logic                  store_stall;
    logic                  evict_valid;
    logic [31:0]           load_data;
    logic [`DC_ADDR_W-1:0] evict_addr;
    logic [`DC_LINE_W-1:0] evict_data;

    // reference model of the cache contents
    logic                  m_valid [`DC_WAYS][`DC_SETS];
    logic                  m_dirty [`DC_WAYS][`DC_SETS];
    logic [`DC_TAG_W-1:0]  m_tag   [`DC_WAYS][`DC_SETS];
    logic [`DC_LINE_W-1:0] m_data  [`DC_WAYS][`DC_SETS];
    int                    m_age   [`DC_WAYS][`DC_SETS];

    // prediction for the request in flight
    req_kind_t               exp_kind;
    int                      exp_set;
    int                      hit_way;
    int                      fill_way;
    logic                    exp_hit;
    logic                    exp_evict;
    logic [`DC_OFFSET_W-1:0] exp_off;
    logic [`DC_TAG_W-1:0]    exp_tag;
    logic [`DC_ADDR_W-1:0]   exp_evict_addr;
    logic [`DC_LINE_W-1:0]   exp_evict_data;
    logic [31:0]             exp_load_data;
    int                      errors = 0;
    int                      cycle_count = 0;

    dcache_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // bit position of a field with lane 0 at the lowest address
    function automatic int field_pos(input logic [2:0] off, input mem_size_t size);
        case (size)
            size_byte: return 8 * int'(off);
            size_half: return 16 * int'(off[2:1]);
            default:   return 32 * int'(off[2]);
        endcase
    endfunction

    function automatic logic [31:0] extract_field(input logic [63:0] line,
                                                  input logic [2:0] off, input mem_size_t size);
        logic [63:0] shifted;
        shifted = line >> field_pos(off, size);
        case (size)
            size_byte: return {24'b0, shifted[7:0]};
            size_half: return {16'b0, shifted[15:0]};
            default:   return shifted[31:0];
        endcase
    endfunction

    function automatic logic [63:0] merge_field(input logic [63:0] line, input logic [2:0] off,
                                                input mem_size_t size, input logic [31:0] data);
        logic [63:0] mask;
        int          pos;
        pos = field_pos(off, size);
        case (size)
            size_byte: mask = 64'hff;
            size_half: mask = 64'hffff;
            default:   mask = 64'hffff_ffff;
        endcase
        return (line & ~(mask << pos)) | ((64'(data) & mask) << pos);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int off);
        return {tag[`DC_TAG_W-1:0], set[`DC_INDEX_W-1:0], off[`DC_OFFSET_W-1:0]};
    endfunction

    // predicted response from the model and the current inputs
    task automatic compute_expected();
        logic [`DC_ADDR_W-1:0] a;
        int                    victim;
        if (refill_valid) exp_kind = req_refill;
        else if (store_valid) exp_kind = req_store;
        else if (load_valid) exp_kind = req_load;
        else exp_kind = req_none;
        a = (exp_kind == req_refill) ? refill_addr :
            (exp_kind == req_store) ? store_addr : load_addr;
        exp_tag = a[`DC_ADDR_W-1:`DC_TAG_LSB];
        exp_set = int'(a[`DC_TAG_LSB-1:`DC_INDEX_LSB]);
        exp_off = a[`DC_INDEX_LSB-1:0];
        exp_hit = 1'b0;
        hit_way = 0;
        victim = 0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (m_valid[w][exp_set] && m_tag[w][exp_set] == exp_tag) begin
                exp_hit = 1'b1;
                hit_way = w;
            end
            // first oldest way is the victim
            if (m_age[w][exp_set] > m_age[victim][exp_set]) victim = w;
        end
        fill_way = exp_hit ? hit_way : victim;
        exp_evict = (exp_kind == req_refill) && !exp_hit &&
                    m_valid[victim][exp_set] && m_dirty[victim][exp_set];
        exp_evict_addr = exp_evict ? {m_tag[victim][exp_set], a[`DC_TAG_LSB-1:`DC_INDEX_LSB],
                                      {`DC_OFFSET_W{1'b0}}} : '0;
        exp_evict_data = exp_evict ? m_data[victim][exp_set] : '0;
        exp_load_data = (exp_kind == req_load && exp_hit) ?
                        extract_field(m_data[hit_way][exp_set], exp_off, load_size) : '0;
    endtask

    task automatic touch_lru(input int s, input int tw);
        int t;
        t = m_age[tw][s];
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (w == tw) m_age[w][s] = 0;
            else if (m_age[w][s] < t) m_age[w][s] = m_age[w][s] + 1;
        end
    endtask

    task automatic check_bits(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
        assert (got === expected) else begin
            $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
            errors++;
        end
    endtask

    // outputs are settled mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            compute_expected();
            check_bits("load_hit", load_hit, exp_kind == req_load && exp_hit);
            check_bits("load_miss", load_miss, exp_kind == req_load && !exp_hit);
            check_bits("load_data", load_data, exp_load_data);
            check_bits("load_stall", load_stall, refill_valid || store_valid);
            check_bits("store_hit", store_hit, exp_kind == req_store && exp_hit);
            check_bits("store_miss", store_miss, exp_kind == req_store && !exp_hit);
            check_bits("store_stall", store_stall, refill_valid);
            check_bits("evict_valid", evict_valid, exp_evict);
            check_bits("evict_addr", evict_addr, exp_evict_addr);
            check_bits("evict_data", evict_data, exp_evict_data);
        end
    end

    // model takes the served request at the edge
    always @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                for (int s = 0; s < `DC_SETS; s++) begin
                    m_valid[w][s] = 1'b0;
                    m_dirty[w][s] = 1'b0;
                    m_age[w][s] = w;
                end
            end
        end else begin
            compute_expected();
            if (exp_kind == req_refill) begin
                m_valid[fill_way][exp_set] = 1'b1;
                m_dirty[fill_way][exp_set] = refill_dirty;
                m_tag[fill_way][exp_set] = exp_tag;
                m_data[fill_way][exp_set] = refill_data;
                touch_lru(exp_set, fill_way);
            end else if (exp_kind == req_store && exp_hit) begin
                m_data[hit_way][exp_set] = merge_field(m_data[hit_way][exp_set], exp_off,
                                                       store_size, store_data);
                m_dirty[hit_way][exp_set] = 1'b1;
                touch_lru(exp_set, hit_way);
            end else if (exp_kind == req_load && exp_hit) begin
                touch_lru(exp_set, hit_way);
            end
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    task automatic issue_load(input logic [31:0] addr, input mem_size_t size);
        load_valid = 1'b1;
        load_addr = addr;
        load_size = size;
        @(negedge clock);
        while (load_stall) @(negedge clock);
        @(posedge clock);
        #1;
        load_valid = 1'b0;
    endtask

    task automatic issue_store(input logic [31:0] addr, input mem_size_t size,
                               input logic [31:0] data);
        store_valid = 1'b1;
        store_addr = addr;
        store_size = size;
        store_data = data;
        @(negedge clock);
        while (store_stall) @(negedge clock);
        @(posedge clock);
        #1;
        store_valid = 1'b0;
    endtask

    task automatic issue_refill(input logic [31:0] addr, input logic [63:0] data,
                                input logic dirty);
        refill_valid = 1'b1;
        refill_addr = addr;
        refill_data = data;
        refill_dirty = dirty;
        @(posedge clock);
        #1;
        refill_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(47338));
        reset = 1'b1;
        load_valid = 1'b0;
        store_valid = 1'b0;
        refill_valid = 1'b0;
        refill_dirty = 1'b0;
        load_addr = '0;
        store_addr = '0;
        refill_addr = '0;
        load_size = size_word;
        store_size = size_word;
        store_data = '0;
        refill_data = '0;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        // empty cache misses everywhere
        for (int i = 0; i < 4; i++) issue_load($urandom, size_word);
        issue_store(make_addr(5, 2, 0), size_word, $urandom);
        issue_load(make_addr(5, 2, 0), size_word);

        // every legal offset of a random line
        issue_refill(make_addr('h12, 3, 0), {$urandom, $urandom}, 1'b0);
        for (int o = 0; o < 8; o++) issue_load(make_addr('h12, 3, o), size_byte);
        for (int o = 0; o < 8; o += 2) issue_load(make_addr('h12, 3, o), size_half);
        for (int o = 0; o < 8; o += 4) issue_load(make_addr('h12, 3, o), size_word);

        // store merge of each size and a store miss
        issue_store(make_addr('h12, 3, 5), size_byte, $urandom);
        issue_load(make_addr('h12, 3, 4), size_word);
        issue_store(make_addr('h12, 3, 2), size_half, $urandom);
        issue_load(make_addr('h12, 3, 0), size_word);
        issue_store(make_addr('h12, 3, 4), size_word, $urandom);
        issue_load(make_addr('h12, 3, 4), size_word);
        issue_store(make_addr('h13, 3, 0), size_word, $urandom);
        issue_load(make_addr('h12, 3, 0), size_word);
        issue_load(make_addr('h13, 3, 0), size_word);

        // lru picks the line not used since its refill
        issue_refill(make_addr('h20, 7, 0), {$urandom, $urandom}, 1'b0);
        issue_refill(make_addr('h21, 7, 0), {$urandom, $urandom}, 1'b0);
        issue_load(make_addr('h20, 7, 0), size_word);
        issue_refill(make_addr('h22, 7, 0), {$urandom, $urandom}, 1'b0);
        issue_load(make_addr('h20, 7, 4), size_word);
        issue_load(make_addr('h21, 7, 0), size_word);
        // same tag again overwrites in place
        issue_refill(make_addr('h22, 7, 0), {$urandom, $urandom}, 1'b0);
        issue_load(make_addr('h22, 7, 0), size_word);

        // both ways of set 9 valid
        issue_refill(make_addr('h30, 9, 0), {$urandom, $urandom}, 1'b0);
        issue_refill(make_addr('h31, 9, 0), {$urandom, $urandom}, 1'b0);
        // store miss leaves the full set alone
        issue_store(make_addr('h34, 9, 0), size_word, $urandom);
        issue_load(make_addr('h31, 9, 0), size_word);
        // store hit makes the dirty line youngest
        issue_store(make_addr('h30, 9, 6), size_half, $urandom);
        // clean victim goes first without write-back
        issue_refill(make_addr('h32, 9, 0), {$urandom, $urandom}, 1'b0);
        issue_refill(make_addr('h33, 9, 0), {$urandom, $urandom}, 1'b0);

        // all three at once
        // refill goes first, store next, load last
        issue_refill(make_addr('h40, 11, 0), {$urandom, $urandom}, 1'b0);
        refill_valid = 1'b1;
        refill_addr = make_addr('h41, 11, 0);
        refill_data = {$urandom, $urandom};
        refill_dirty = 1'b1;
        store_valid = 1'b1;
        store_addr = make_addr('h40, 11, 1);
        store_size = size_byte;
        store_data = $urandom;
        issue_load(make_addr('h40, 11, 0), size_word);
        // refill-dirty line is the next victim
        issue_refill(make_addr('h42, 11, 0), {$urandom, $urandom}, 1'b0);
        repeat (2) @(posedge clock);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // single-cycle grants in the contention case
    always @(posedge clock) begin
        if (!reset && refill_valid && store_valid) begin
            #1;
            refill_valid = 1'b0;
        end else if (!reset && store_valid && load_valid && !refill_valid) begin
            #1;
            store_valid = 1'b0;
        end
    end

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic                   clock,
    input  logic                   reset,
    // load port
    input  logic                   load_valid,
    input  logic [`DC_ADDR_W-1:0]  load_addr,
    input  dcache_pkg::mem_size_t  load_size,
    // store port
    input  logic                   store_valid,
    input  logic [`DC_ADDR_W-1:0]  store_addr,
    input  dcache_pkg::mem_size_t  store_size,
    input  logic [31:0]            store_data,
    // refill from the miss handler
    input  logic                   refill_valid,
    input  logic [`DC_ADDR_W-1:0]  refill_addr,
    input  logic [`DC_LINE_W-1:0]  refill_data,
    input  logic                   refill_dirty,
    // load result
    output logic                   load_hit,
    output logic                   load_miss,
    output logic [31:0]            load_data,
    output logic                   load_stall,
    // store result
    output logic                   store_hit,
    output logic                   store_miss,
    output logic                   store_stall,
    // write-back of a dirty victim
    output logic                   evict_valid,
    output logic [`DC_ADDR_W-1:0]  evict_addr,
    output logic [`DC_LINE_W-1:0]  evict_data
);
    import dcache_pkg::*;

    // lru lookup and touch
    logic [`DC_INDEX_W-1:0]  lookup_set;
    logic [`DC_WAY_W-1:0]    victim_way;
    logic                    touch_en;
    logic [`DC_INDEX_W-1:0]  touch_set;
    logic [`DC_WAY_W-1:0]    touch_way;

    // aligner traffic
    line_view_t              sel_line;
    line_view_t              merged_line;
    logic [`DC_OFFSET_W-1:0] access_offset;
    mem_size_t               access_size;
    logic [31:0]             access_data;
    logic [31:0]             load_word;

    cache_ways u_ways (
        .clock         (clock),
        .reset         (reset),
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_size     (load_size),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_size    (store_size),
        .store_data    (store_data),
        .refill_valid  (refill_valid),
        .refill_addr   (refill_addr),
        .refill_data   (refill_data),
        .refill_dirty  (refill_dirty),
        .victim_way    (victim_way),
        .merged_line   (merged_line),
        .load_word     (load_word),
        .load_hit      (load_hit),
        .load_miss     (load_miss),
        .load_data     (load_data),
        .load_stall    (load_stall),
        .store_hit     (store_hit),
        .store_miss    (store_miss),
        .store_stall   (store_stall),
        .evict_valid   (evict_valid),
        .evict_addr    (evict_addr),
        .evict_data    (evict_data),
        .lookup_set    (lookup_set),
        .touch_en      (touch_en),
        .touch_set     (touch_set),
        .touch_way     (touch_way),
        .sel_line      (sel_line),
        .access_offset (access_offset),
        .access_size   (access_size),
        .access_data   (access_data)
    );

    way_lru u_lru (
        .clock      (clock),
        .reset      (reset),
        .lookup_set (lookup_set),
        .touch_en   (touch_en),
        .touch_set  (touch_set),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

    line_align u_align (
        .sel_line      (sel_line),
        .access_offset (access_offset),
        .access_size   (access_size),
        .access_data   (access_data),
        .merged_line   (merged_line),
        .load_word     (load_word)
    );

endmodule

/* hdl/cache_ways.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module cache_ways (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          load_valid,
    input  logic [`DC_ADDR_W-1:0]         load_addr,
    input  dcache_pkg::mem_size_t         load_size,
    input  logic                          store_valid,
    input  logic [`DC_ADDR_W-1:0]         store_addr,
    input  dcache_pkg::mem_size_t         store_size,
    input  logic [31:0]                   store_data,
    input  logic                          refill_valid,
    input  logic [`DC_ADDR_W-1:0]         refill_addr,
    input  logic [`DC_LINE_W-1:0]         refill_data,
    input  logic                          refill_dirty,
    input  logic [`DC_WAY_W-1:0]          victim_way,
    input  dcache_pkg::line_view_t        merged_line,
    input  logic [31:0]                   load_word,
    output logic                          load_hit,
    output logic                          load_miss,
    output logic [31:0]                   load_data,
    output logic                          load_stall,
    output logic                          store_hit,
    output logic                          store_miss,
    output logic                          store_stall,
    output logic                          evict_valid,
    output logic [`DC_ADDR_W-1:0]         evict_addr,
    output logic [`DC_LINE_W-1:0]         evict_data,
    output logic [`DC_INDEX_W-1:0]        lookup_set,
    output logic                          touch_en,
    output logic [`DC_INDEX_W-1:0]        touch_set,
    output logic [`DC_WAY_W-1:0]          touch_way,
    output dcache_pkg::line_view_t        sel_line,
    output logic [`DC_OFFSET_W-1:0]       access_offset,
    output dcache_pkg::mem_size_t         access_size,
    output logic [31:0]                   access_data
);
    import dcache_pkg::*;

    // per-line valid, dirty, tag and data
    logic [`DC_SETS-1:0]   valid_bits [`DC_WAYS];
    logic [`DC_SETS-1:0]   dirty_bits [`DC_WAYS];
    logic [`DC_TAG_W-1:0]  tag_mem    [`DC_WAYS][`DC_SETS];
    logic [`DC_LINE_W-1:0] data_mem   [`DC_WAYS][`DC_SETS];

    req_kind_t               kind;
    logic [`DC_ADDR_W-1:0]   addr;
    logic [`DC_TAG_W-1:0]    tag;
    logic [`DC_INDEX_W-1:0]  idx;
    logic [`DC_OFFSET_W-1:0] offset;
    logic [`DC_WAYS-1:0]     hit_vec;
    logic                    hit;
    logic [`DC_WAY_W-1:0]    hit_way;
    logic [`DC_WAY_W-1:0]    fill_way;
    logic                    victim_dirty;
    logic                    is_refill;

    // fixed priority picks one request per cycle
    always_comb begin
        if (refill_valid) begin
            kind = req_refill;
        end else if (store_valid) begin
            kind = req_store;
        end else if (load_valid) begin
            kind = req_load;
        end else begin
            kind = req_none;
        end
    end

    // losers hold their request
    assign store_stall = refill_valid;
    assign load_stall  = refill_valid || store_valid;

    always_comb begin
        case (kind)
            req_refill: addr = refill_addr;
            req_store:  addr = store_addr;
            default:    addr = load_addr;
        endcase
    end

    assign tag    = addr[`DC_ADDR_W-1:`DC_TAG_LSB];
    assign idx    = addr[`DC_TAG_LSB-1:`DC_INDEX_LSB];
    assign offset = addr[`DC_INDEX_LSB-1:0];

    // tag compare across all ways of the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid_bits[w][idx] && (tag_mem[w][idx] == tag);
            if (hit_vec[w]) begin
                hit_way = w[`DC_WAY_W-1:0];
            end
        end
    end

    assign hit       = |hit_vec;
    assign is_refill = (kind == req_refill);

    // refill reuses a matching way, else takes the lru victim
    assign fill_way     = hit ? hit_way : victim_way;
    assign victim_dirty = valid_bits[victim_way][idx] && dirty_bits[victim_way][idx];

    // old line goes out only when it is replaced and dirty
    assign evict_valid = is_refill && !hit && victim_dirty;
    assign evict_addr  = evict_valid ?
                         {tag_mem[victim_way][idx], idx, {`DC_OFFSET_W{1'b0}}} : '0;
    assign evict_data  = evict_valid ? data_mem[victim_way][idx] : '0;

    // hit and miss flags
    assign store_hit  = (kind == req_store) && hit;
    assign store_miss = (kind == req_store) && !hit;
    assign load_hit   = (kind == req_load) && hit;
    assign load_miss  = (kind == req_load) && !hit;
    assign load_data  = load_hit ? load_word : '0;

    // lru lookup and age update
    assign lookup_set = idx;
    assign touch_en   = is_refill || store_hit || load_hit;
    assign touch_set  = idx;
    assign touch_way  = is_refill ? fill_way : hit_way;

    // hit line to the aligner
    assign sel_line      = data_mem[hit_way][idx];
    assign access_offset = offset;
    assign access_size   = (kind == req_store) ? store_size : load_size;
    assign access_data   = store_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
        end else if (is_refill) begin
            valid_bits[fill_way][idx] <= 1'b1;
            dirty_bits[fill_way][idx] <= refill_dirty;
        end else if (store_hit) begin
            dirty_bits[hit_way][idx] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clock) begin
        if (is_refill) begin
            tag_mem[fill_way][idx]  <= tag;
            data_mem[fill_way][idx] <= refill_data;
        end else if (store_hit) begin
            data_mem[hit_way][idx] <= merged_line;
        end
    end

endmodule

/* hdl/way_lru.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module way_lru (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`DC_INDEX_W-1:0] lookup_set,
    input  logic                   touch_en,
    input  logic [`DC_INDEX_W-1:0] touch_set,
    input  logic [`DC_WAY_W-1:0]   touch_way,
    output logic [`DC_WAY_W-1:0]   victim_way
);

    // age 0 is most recent, largest age is the victim
    logic [`DC_WAY_W-1:0] age [`DC_WAYS][`DC_SETS];
    logic [`DC_WAY_W-1:0] touched_age;
    logic [`DC_WAY_W-1:0] oldest_age;

    assign touched_age = age[touch_way][touch_set];

    always_ff @(posedge clock) begin
        if (reset) begin
            // way i starts at age i
            for (int w = 0; w < `DC_WAYS; w++) begin
                for (int s = 0; s < `DC_SETS; s++) begin
                    age[w][s] <= w[`DC_WAY_W-1:0];
                end
            end
        end else if (touch_en) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (w == touch_way) begin
                    age[w][touch_set] <= '0;
                end else if (age[w][touch_set] < touched_age) begin
                    // younger ways age by one
                    age[w][touch_set] <= age[w][touch_set] + 1'b1;
                end
            end
        end
    end

    // oldest way of the looked-up set
    always_comb begin
        victim_way = '0;
        oldest_age = age[0][lookup_set];
        for (int w = 1; w < `DC_WAYS; w++) begin
            if (age[w][lookup_set] > oldest_age) begin
                oldest_age = age[w][lookup_set];
                victim_way = w[`DC_WAY_W-1:0];
            end
        end
    end

endmodule

/* hdl/line_align.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module line_align (
    input  dcache_pkg::line_view_t   sel_line,
    input  logic [`DC_OFFSET_W-1:0]  access_offset,
    input  dcache_pkg::mem_size_t    access_size,
    input  logic [31:0]              access_data,
    output dcache_pkg::line_view_t   merged_line,
    output logic [31:0]              load_word
);
    import dcache_pkg::*;

    localparam int HALF_SEL_W = `DC_OFFSET_W - 1;
    localparam int WORD_SEL_W = `DC_OFFSET_W - 2;

    // lane index per access size
    logic [`DC_OFFSET_W-1:0] byte_sel;
    logic [HALF_SEL_W-1:0]   half_sel;
    logic [WORD_SEL_W-1:0]   word_sel;

    assign byte_sel = access_offset;
    // low offset bits dropped, halves and words are aligned
    assign half_sel = access_offset[`DC_OFFSET_W-1:1];
    assign word_sel = access_offset[`DC_OFFSET_W-1:2];

    // store merge, rest of the line untouched
    always_comb begin
        merged_line = sel_line;
        case (access_size)
            size_byte: begin
                merged_line.byte_lane[byte_sel] = access_data[7:0];
            end
            size_half: begin
                merged_line.half_lane[half_sel] = access_data[15:0];
            end
            size_word: begin
                merged_line.word_lane[word_sel] = access_data;
            end
            default: begin
                // unknown size leaves the line as is
                merged_line = sel_line;
            end
        endcase
    end

    // load extract, zero extended
    always_comb begin
        case (access_size)
            size_byte: begin
                load_word = {24'b0, sel_line.byte_lane[byte_sel]};
            end
            size_half: begin
                load_word = {16'b0, sel_line.half_lane[half_sel]};
            end
            size_word: begin
                load_word = sel_line.word_lane[word_sel];
            end
            default: begin
                load_word = '0;
            end
        endcase
    end

endmodule

/* hdl/dcache_pkg.sv */
`include "dcache_defines.svh"

package dcache_pkg;

    // access width of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    // request served in the current cycle
    // refill beats store beats load
    typedef enum logic [1:0] {
        req_none   = 2'd0,
        req_refill = 2'd1,
        req_store  = 2'd2,
        req_load   = 2'd3
    } req_kind_t;

    // one cache line seen three ways
    // lane 0 sits at the lowest address
    typedef union packed {
        logic [`DC_LINE_BYTES-1:0][7:0]    byte_lane;
        logic [`DC_LINE_BYTES/2-1:0][15:0] half_lane;
        logic [`DC_LINE_BYTES/4-1:0][31:0] word_lane;
    } line_view_t;

endpackage

/* hdl/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// address width in bits
`define DC_ADDR_W 32

// cache geometry
`define DC_WAYS 2
`define DC_SETS 16
`define DC_LINE_BYTES 8

// derived widths
`define DC_LINE_W (`DC_LINE_BYTES * 8)
`define DC_WAY_W ($clog2(`DC_WAYS))

// address split: tag | index | offset
`define DC_OFFSET_W 3
`define DC_INDEX_W 4
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

// low bit of each address field
`define DC_INDEX_LSB (`DC_OFFSET_W)
`define DC_TAG_LSB (`DC_OFFSET_W + `DC_INDEX_W)

`endif
